// File: Makefile
TOP := pe_control_unit_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build output"

test:
	verilator --binary --timing --assert -f pe_control_unit.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir

// File: pe_control_unit.f
source/pe_ctrl_pkg.sv
source/sync_fifo.sv
source/burst_reader.sv
source/mac_sequencer.sv
source/burst_writer.sv
source/pe_control_unit.sv
verification/tb_clock_gen.sv
verification/pe_control_unit_checker.sv
verification/pe_control_unit_tb.sv

// File: source/burst_reader.sv
// ======================================================================
// psum read burst FSM, steers read beats into the psum FIFO
// ======================================================================
`timescale 1ns/1ps
module burst_reader import pe_ctrl_pkg::*; (
  input  logic     CLK,
  input  logic     resetn_all,
  input  logic     buffer_psums,
  input  word_t    psum_base,
  output mem_cmd_t rd_cmd,
  input  rd_beat_t rd_beat,
  input  logic     txn_done,
  input  logic     axi_error,
  input  logic     fifo_full,
  output logic     fifo_wr,
  output word_t    fifo_wr_data,
  output logic     psums_buffered,
  output logic     psum_buffer_error
);
  localparam int CNT_W = $clog2(PSUM_BURSTS) + 1;

  rd_state_t        state;
  logic             buffer_q;
  logic             start_pulse;
  logic             last_burst;
  logic [CNT_W-1:0] burst_cnt;
  word_t            addr_off;

  assign start_pulse = buffer_psums & ~buffer_q;
  assign last_burst  = (burst_cnt == CNT_W'(PSUM_BURSTS - 1));

  // beats only belong to us while a read burst is open
  assign fifo_wr      = (state == rd_wait) && rd_beat.valid;
  assign fifo_wr_data = rd_beat.data;

  always_ff @(posedge CLK) begin
    if (!resetn_all) begin
      state             <= rd_idle;
      buffer_q          <= 1'b0;
      burst_cnt         <= '0;
      addr_off          <= '0;
      rd_cmd            <= '0;
      psums_buffered    <= 1'b0;
      psum_buffer_error <= 1'b0;
    end else begin
      buffer_q    <= buffer_psums;
      rd_cmd.init <= 1'b0;
      case (state)
        rd_idle: begin
          if (start_pulse) begin
            state             <= rd_issue;
            burst_cnt         <= '0;
            addr_off          <= '0;
            psums_buffered    <= 1'b0;
            psum_buffer_error <= 1'b0;
          end
        end
        rd_issue: begin
          rd_cmd.init <= 1'b1;
          rd_cmd.addr <= psum_base + addr_off;
          addr_off    <= addr_off + word_t'(BURST_BYTES);
          state       <= rd_wait;
        end
        rd_wait: begin
          // overflow drops the word and flags it
          if (fifo_wr && fifo_full) begin
            psum_buffer_error <= 1'b1;
          end
          if (txn_done) begin
            state <= rd_done;
            if (last_burst) begin
              psums_buffered <= 1'b1;
            end
          end
        end
        rd_done: begin
          // bus error shows up the cycle after done
          if (axi_error) begin
            psum_buffer_error <= 1'b1;
          end
          burst_cnt <= burst_cnt + 1'b1;
          state     <= last_burst ? rd_idle : rd_issue;
        end
        default: state <= rd_idle;
      endcase
    end
  end

endmodule

// File: source/burst_writer.sv
// ======================================================================
// output write burst FSM, drains the output FIFO into memory
// ======================================================================
`timescale 1ns/1ps
module burst_writer import pe_ctrl_pkg::*; (
  input  logic     CLK,
  input  logic     resetn_all,
  input  logic     output_buffering,
  input  word_t    output_base,
  output mem_cmd_t wr_cmd,
  input  logic     wr_accept,
  input  logic     txn_done,
  input  logic     axi_error,
  output logic     fifo_rd,
  output logic     output_written,
  output logic     output_write_error
);
  localparam int CNT_W = $clog2(OUT_BURSTS) + 1;

  wr_state_t        state;
  logic [CNT_W-1:0] burst_cnt;
  word_t            addr_off;

  // head of the FIFO leaves on every accepted beat
  assign fifo_rd = (state == wr_wait) && wr_accept;

  always_ff @(posedge CLK) begin
    if (!resetn_all) begin
      state              <= wr_wait_out;
      burst_cnt          <= '0;
      addr_off           <= '0;
      wr_cmd             <= '0;
      output_written     <= 1'b0;
      output_write_error <= 1'b0;
    end else begin
      wr_cmd.init <= 1'b0;
      case (state)
        wr_wait_out: begin
          burst_cnt <= '0;
          addr_off  <= '0;
          if (output_buffering) begin
            output_written     <= 1'b0;
            output_write_error <= 1'b0;
            state              <= wr_issue;
          end
        end
        wr_issue: begin
          // hold off until the whole run is in the FIFO
          if (!output_buffering) begin
            wr_cmd.init <= 1'b1;
            wr_cmd.addr <= output_base + addr_off;
            addr_off    <= addr_off + word_t'(BURST_BYTES);
            burst_cnt   <= burst_cnt + 1'b1;
            state       <= wr_wait;
          end
        end
        wr_wait: begin
          if (txn_done) begin
            state <= wr_next;
          end
        end
        wr_next: begin
          if (axi_error) begin
            output_write_error <= 1'b1;
          end
          if (burst_cnt != CNT_W'(OUT_BURSTS)) begin
            state <= wr_issue;
          end else begin
            output_written <= 1'b1;
            state          <= wr_wait_out;
          end
        end
        default: state <= wr_wait_out;
      endcase
    end
  end

endmodule

// File: source/mac_sequencer.sv
// ======================================================================
// MAC array sequencer: mux controls, run counters, stalls and
// output buffering window
// ======================================================================
`timescale 1ns/1ps
module mac_sequencer import pe_ctrl_pkg::*; (
  input  logic              CLK,
  input  logic              resetn_all,
  input  acc_params_t       params,
  input  logic              act_valid,
  output logic              stall_ctrl,
  output logic              psum_rd,
  output logic              out_fifo_wr,
  output logic              busy,
  output logic              output_buffering,
  output logic [0:PE_COLS-1] add_mux_ctrl [PE_ROWS],
  output row_sel_t          row_out_mux_ctrl [PE_ROWS],
  output psum_sel_t         psum_out_mux_ctrl
);
  localparam int PIPE_W = $clog2(MAC_PIPE_DEPTH) + 1;

  logic              start_q;
  logic              start_pulse;
  logic              running;
  logic [PIPE_W-1:0] pipe_cnt;
  dim_t              col_cnt;
  dim_t              row_cnt;
  count_t            out_cnt;
  count_t            out_limit;

  assign start_pulse = params.start & ~start_q;
  assign out_limit   = count_t'(params.tile) * count_t'(params.r);

  // no stalls outside the compute phase
  assign stall_ctrl  = running & ~act_valid;
  assign psum_rd     = running & act_valid;
  assign out_fifo_wr = output_buffering;
  assign busy        = running | output_buffering;

  // mux controls load on a valid parameter word
  always_ff @(posedge CLK) begin
    if (!resetn_all) begin
      for (int r = 0; r < PE_ROWS; r++) begin
        add_mux_ctrl[r]     <= '0;
        row_out_mux_ctrl[r] <= '0;
      end
      psum_out_mux_ctrl <= '0;
    end else if (params.valid) begin
      for (int r = 0; r < PE_ROWS; r++) begin
        for (int c = 0; c < PE_COLS; c++) begin
          add_mux_ctrl[r][c] <= (r < int'(params.r)) && (c < int'(params.s));
        end
        row_out_mux_ctrl[r] <= row_sel_t'(params.tile - 4'd1);
      end
      psum_out_mux_ctrl <= psum_sel_t'(params.r - 4'd1);
    end
  end

  always_ff @(posedge CLK) begin
    if (!resetn_all) begin
      start_q          <= 1'b0;
      running          <= 1'b0;
      output_buffering <= 1'b0;
      pipe_cnt         <= '0;
      col_cnt          <= '0;
      row_cnt          <= '0;
      out_cnt          <= '0;
    end else begin
      start_q <= params.start;
      if (!running && !output_buffering) begin
        if (start_pulse) begin
          running  <= 1'b1;
          pipe_cnt <= '0;
          col_cnt  <= '0;
          row_cnt  <= '0;
        end
      end else if (running) begin
        // counters hold while activations are invalid
        if (act_valid) begin
          if (pipe_cnt != PIPE_W'(MAC_PIPE_DEPTH)) begin
            pipe_cnt <= pipe_cnt + 1'b1;
          end else if (col_cnt != params.tile - 4'd1) begin
            col_cnt <= col_cnt + 1'b1;
          end else begin
            col_cnt <= '0;
            if (row_cnt != params.r) begin
              row_cnt <= row_cnt + 1'b1;
            end else begin
              row_cnt          <= '0;
              running          <= 1'b0;
              output_buffering <= (out_limit != '0);
              out_cnt          <= '0;
            end
          end
        end
      end else begin
        // tile x R output words at one per cycle
        if (out_cnt == out_limit - 8'd1) begin
          output_buffering <= 1'b0;
        end else begin
          out_cnt <= out_cnt + 1'b1;
        end
      end
    end
  end

endmodule

// File: source/pe_control_unit.sv
// ======================================================================
// PE control unit top: psum read, MAC sequencing, output write-back
// and the status register
// ======================================================================
`timescale 1ns/1ps
module pe_control_unit import pe_ctrl_pkg::*; (
  input  logic              CLK,
  input  logic              resetn_all,
  input  acc_params_t       params,
  input  word_t             psum_base,
  input  word_t             output_base,
  input  mem_ctrl_t         mem_ctrl,
  output pe_status_t        pe_status,
  input  logic              act_valid,
  output logic              stall_ctrl,
  output logic [0:PE_COLS-1] add_mux_ctrl [PE_ROWS],
  output row_sel_t          row_out_mux_ctrl [PE_ROWS],
  output psum_sel_t         psum_out_mux_ctrl,
  output word_t             in_psum_out,
  input  word_t             out_psum_in,
  output mem_cmd_t          rd_cmd,
  input  rd_beat_t          rd_beat,
  output mem_cmd_t          wr_cmd,
  output word_t             wr_data,
  input  logic              wr_accept,
  input  logic              txn_done,
  input  logic              axi_error
);
  logic       clear_out_q;
  logic       clear_psum_q;
  logic       clear_out_pulse;
  logic       clear_psum_pulse;
  logic       psum_wr;
  word_t      psum_wr_data;
  logic       psum_full;
  logic       psum_rd;
  logic       out_wr;
  logic       out_full;
  logic       out_rd;
  logic       busy;
  logic       output_buffering;
  logic       psums_buffered;
  logic       psum_buffer_error;
  logic       output_written;
  logic       wr_error;
  logic       out_ovf;
  pe_status_t status_d;

  assign clear_out_pulse  = mem_ctrl.clear_output & ~clear_out_q;
  assign clear_psum_pulse = mem_ctrl.clear_psum & ~clear_psum_q;

  always_ff @(posedge CLK) begin
    if (!resetn_all) begin
      clear_out_q  <= 1'b0;
      clear_psum_q <= 1'b0;
      out_ovf      <= 1'b0;
    end else begin
      clear_out_q  <= mem_ctrl.clear_output;
      clear_psum_q <= mem_ctrl.clear_psum;
      // sticky until the output buffer is cleared
      if (clear_out_pulse) begin
        out_ovf <= 1'b0;
      end else if (out_wr && out_full) begin
        out_ovf <= 1'b1;
      end
    end
  end

  burst_reader u_reader (
    .CLK               (CLK),
    .resetn_all        (resetn_all),
    .buffer_psums      (mem_ctrl.buffer_psums),
    .psum_base         (psum_base),
    .rd_cmd            (rd_cmd),
    .rd_beat           (rd_beat),
    .txn_done          (txn_done),
    .axi_error         (axi_error),
    .fifo_full         (psum_full),
    .fifo_wr           (psum_wr),
    .fifo_wr_data      (psum_wr_data),
    .psums_buffered    (psums_buffered),
    .psum_buffer_error (psum_buffer_error)
  );

  mac_sequencer u_sequencer (
    .CLK               (CLK),
    .resetn_all        (resetn_all),
    .params            (params),
    .act_valid         (act_valid),
    .stall_ctrl        (stall_ctrl),
    .psum_rd           (psum_rd),
    .out_fifo_wr       (out_wr),
    .busy              (busy),
    .output_buffering  (output_buffering),
    .add_mux_ctrl      (add_mux_ctrl),
    .row_out_mux_ctrl  (row_out_mux_ctrl),
    .psum_out_mux_ctrl (psum_out_mux_ctrl)
  );

  burst_writer u_writer (
    .CLK                (CLK),
    .resetn_all         (resetn_all),
    .output_buffering   (output_buffering),
    .output_base        (output_base),
    .wr_cmd             (wr_cmd),
    .wr_accept          (wr_accept),
    .txn_done           (txn_done),
    .axi_error          (axi_error),
    .fifo_rd            (out_rd),
    .output_written     (output_written),
    .output_write_error (wr_error)
  );

  // psums from memory toward the array
  sync_fifo #(.DEPTH(FIFO_DEPTH)) psum_fifo (
    .CLK        (CLK),
    .resetn_all (resetn_all),
    .clear      (clear_psum_pulse),
    .wr         (psum_wr),
    .wr_data    (psum_wr_data),
    .rd         (psum_rd),
    .rd_data    (in_psum_out),
    .empty      (),
    .full       (psum_full)
  );

  // array outputs toward memory
  sync_fifo #(.DEPTH(FIFO_DEPTH)) out_fifo (
    .CLK        (CLK),
    .resetn_all (resetn_all),
    .clear      (clear_out_pulse),
    .wr         (out_wr),
    .wr_data    (out_psum_in),
    .rd         (out_rd),
    .rd_data    (wr_data),
    .empty      (),
    .full       (out_full)
  );

  always_comb begin
    status_d                    = '0;
    status_d.busy               = busy;
    status_d.output_buffering   = output_buffering;
    status_d.output_written     = output_written;
    status_d.psums_buffered     = psums_buffered;
    status_d.output_write_error = wr_error | out_ovf;
    status_d.psum_buffer_error  = psum_buffer_error;
  end

  always_ff @(posedge CLK) begin
    if (!resetn_all) begin
      pe_status <= '0;
    end else begin
      pe_status <= status_d;
    end
  end

endmodule

// File: source/pe_ctrl_pkg.sv
// ======================================================================
// pe control unit shared widths, burst constants and port types
// ======================================================================
package pe_ctrl_pkg;

  localparam int DATA_W         = 32;
  localparam int PE_ROWS        = 5;
  localparam int PE_COLS        = 5;
  localparam int MAC_PIPE_DEPTH = 2;
  localparam int BURST_LEN      = 4;
  localparam int PSUM_BURSTS    = 2;
  localparam int OUT_BURSTS     = 2;
  localparam int BURST_BYTES    = 16;
  localparam int FIFO_DEPTH     = 16;

  typedef logic [DATA_W-1:0] word_t;
  typedef logic [3:0]        dim_t;
  typedef logic [3:0]        row_sel_t;
  typedef logic [2:0]        psum_sel_t;
  typedef logic [7:0]        count_t;

  // parameter word fields in register map order
  typedef struct packed {
    logic       valid;
    logic       start;
    logic [13:0] rsvd_hi;
    dim_t       tile;
    logic [3:0] rsvd_lo;
    dim_t       s;
    dim_t       r;
  } acc_params_t;

  typedef struct packed {
    logic clear_psum;
    logic buffer_psums;
    logic clear_output;
  } mem_ctrl_t;

  typedef struct packed {
    logic  init;
    word_t addr;
  } mem_cmd_t;

  typedef struct packed {
    logic  valid;
    word_t data;
  } rd_beat_t;

  // progress flags in the low half and error flags in the high half
  typedef struct packed {
    logic [13:0] rsvd_hi;
    logic        psum_buffer_error;
    logic        output_write_error;
    logic [11:0] rsvd_lo;
    logic        psums_buffered;
    logic        output_written;
    logic        output_buffering;
    logic        busy;
  } pe_status_t;

  typedef enum logic [1:0] {rd_idle, rd_issue, rd_wait, rd_done} rd_state_t;
  typedef enum logic [1:0] {wr_wait_out, wr_issue, wr_wait, wr_next} wr_state_t;

endpackage

// File: source/sync_fifo.sv
// ======================================================================
// synchronous FIFO with show-ahead head and single-cycle clear
// ======================================================================
`timescale 1ns/1ps
module sync_fifo import pe_ctrl_pkg::*; #(
  parameter int DEPTH = FIFO_DEPTH
) (
  input  logic  CLK,
  input  logic  resetn_all,
  input  logic  clear,
  input  logic  wr,
  input  word_t wr_data,
  input  logic  rd,
  output word_t rd_data,
  output logic  empty,
  output logic  full
);
  localparam int AW = $clog2(DEPTH);

  word_t         mem [DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [AW:0]   count;
  logic          wr_ok;
  logic          rd_ok;

  // writes into a full buffer are dropped
  assign wr_ok   = wr & ~full;
  assign rd_ok   = rd & ~empty;
  assign empty   = (count == '0);
  assign full    = (count == (AW+1)'(DEPTH));
  assign rd_data = mem[rd_ptr];

  always_ff @(posedge CLK) begin
    if (wr_ok) begin
      mem[wr_ptr] <= wr_data;
    end
  end

  always_ff @(posedge CLK) begin
    if (!resetn_all || clear) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_ok) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_ok) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      count <= count + (AW+1)'(wr_ok) - (AW+1)'(rd_ok);
    end
  end

endmodule

// File: verification/pe_control_unit_checker.sv
// ======================================================================
// bound protocol assertions for the PE control unit
// ======================================================================
`timescale 1ns/1ps
module pe_control_unit_checker import pe_ctrl_pkg::*; (
  input logic     CLK,
  input logic     resetn_all,
  input mem_cmd_t rd_cmd,
  input mem_cmd_t wr_cmd,
  input logic     stall_ctrl,
  input logic     output_buffering
);

  // reads and writes never share the bus
  no_cmd_overlap: assert property (@(posedge CLK) disable iff (!resetn_all)
    !(rd_cmd.init && wr_cmd.init))
    else $error("read and write commands issued in the same cycle");

  rd_init_pulse: assert property (@(posedge CLK) disable iff (!resetn_all)
    rd_cmd.init |=> !rd_cmd.init)
    else $error("read command start held longer than one cycle");

  wr_init_pulse: assert property (@(posedge CLK) disable iff (!resetn_all)
    wr_cmd.init |=> !wr_cmd.init)
    else $error("write command start held longer than one cycle");

  // output window is stall free
  no_stall_in_output: assert property (@(posedge CLK) disable iff (!resetn_all)
    output_buffering |-> !stall_ctrl)
    else $error("stall raised while output buffering");

endmodule

bind pe_control_unit pe_control_unit_checker u_checker (
  .CLK              (CLK),
  .resetn_all       (resetn_all),
  .rd_cmd           (rd_cmd),
  .wr_cmd           (wr_cmd),
  .stall_ctrl       (stall_ctrl),
  .output_buffering (output_buffering)
);

// File: verification/pe_control_unit_golden.txt
// per test, row 1: R S tile psum_base output_base axi_error add_mux row_sel psum_sel
// add_mux holds bit (r,c) at r*5+c; row 2: the 8 psum memory words in read order
// test 0: tile 4, R 2
2 3 4 00001000 00002000 0 000000e7 3 1
11110000 11110001 22220002 22220003 33330004 33330005 44440006 44440007
// test 1: tile 2, R 4, bus error on the last read burst
4 5 2 00003040 00004080 1 000fffff 1 3
a5a50010 5a5a0011 0f0f0012 f0f00013 12340014 56780015 9abc0016 def00017
// test 2: tile 8, R 1
1 2 8 00005000 00006100 0 00000003 7 0
deadbe00 deadbe01 cafe0002 cafe0003 0badf004 0badf005 76540006 fedc0007

// File: verification/pe_control_unit_tb.sv
// ======================================================================
// PE control unit testbench: burst memory model, run stimulus and
// checks against the golden data file
// ======================================================================
`timescale 1ns/1ps
module pe_control_unit_tb import pe_ctrl_pkg::*;;
  localparam int NUM_TESTS       = 3;
  localparam int CYCLES_PER_TEST = 2000;
  localparam int PSUM_WORDS      = PSUM_BURSTS * BURST_LEN;
  localparam int OUT_WORDS       = OUT_BURSTS * BURST_LEN;
  // golden record layout
  localparam int F_R     = 0;
  localparam int F_S     = 1;
  localparam int F_TILE  = 2;
  localparam int F_PBASE = 3;
  localparam int F_OBASE = 4;
  localparam int F_ERR   = 5;
  localparam int F_ADD   = 6;
  localparam int F_ROW   = 7;
  localparam int F_PSUM  = 8;
  localparam int F_MEM   = 9;
  localparam int FIELDS  = F_MEM + PSUM_WORDS;

  logic               CLK;
  logic               resetn_all;
  acc_params_t        params;
  word_t              psum_base;
  word_t              output_base;
  mem_ctrl_t          mem_ctrl;
  pe_status_t         pe_status;
  logic               act_valid;
  logic               stall_ctrl;
  logic [0:PE_COLS-1] add_mux_ctrl [PE_ROWS];
  row_sel_t           row_out_mux_ctrl [PE_ROWS];
  psum_sel_t          psum_out_mux_ctrl;
  word_t              in_psum_out;
  word_t              out_psum_in = '0;
  mem_cmd_t           rd_cmd;
  rd_beat_t           rd_beat;
  mem_cmd_t           wr_cmd;
  word_t              wr_data;
  logic               wr_accept;
  logic               txn_done;
  logic               axi_error;

  word_t golden [NUM_TESTS * FIELDS];
  word_t cur_mem [PSUM_WORDS];
  word_t written_q [$];
  word_t out_first;

  tb_clock_gen #(.PERIOD_NS(8), .RESET_CYCLES(5)) clock_gen (
    .CLK        (CLK),
    .resetn_all (resetn_all)
  );

  pe_control_unit UUT (
    .CLK               (CLK),
    .resetn_all        (resetn_all),
    .params            (params),
    .psum_base         (psum_base),
    .output_base       (output_base),
    .mem_ctrl          (mem_ctrl),
    .pe_status         (pe_status),
    .act_valid         (act_valid),
    .stall_ctrl        (stall_ctrl),
    .add_mux_ctrl      (add_mux_ctrl),
    .row_out_mux_ctrl  (row_out_mux_ctrl),
    .psum_out_mux_ctrl (psum_out_mux_ctrl),
    .in_psum_out       (in_psum_out),
    .out_psum_in       (out_psum_in),
    .rd_cmd            (rd_cmd),
    .rd_beat           (rd_beat),
    .wr_cmd            (wr_cmd),
    .wr_data           (wr_data),
    .wr_accept         (wr_accept),
    .txn_done          (txn_done),
    .axi_error         (axi_error)
  );

  // array output stand-in that steps once per cycle
  always @(posedge CLK) begin
    out_psum_in <= out_psum_in + 1'b1;
  end

  task automatic abort_run(input string line);
    $display("%s", line);
    $display("Simulation failed");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic report_mismatch(input string name, input word_t expected, input word_t actual);
    abort_run($sformatf("mismatch at %0t ns: %s expected %h got %h",
                        $time, name, expected, actual));
  endtask

  task automatic watch_bus_idle(input int cycles);
    repeat (cycles) begin
      @(negedge CLK);
      assert (!rd_cmd.init && !wr_cmd.init) else
        abort_run($sformatf("at %0t ns a burst was issued after the last one", $time));
    end
  endtask

  task automatic load_psum_words(input int t, input logic invert);
    for (int i = 0; i < PSUM_WORDS; i++) begin
      cur_mem[i] = invert ? ~golden[t*FIELDS+F_MEM+i] : golden[t*FIELDS+F_MEM+i];
    end
  endtask

  task automatic apply_params(input int t);
    int    g;
    int    gold_bit;
    int    rule_bit;
    g = t * FIELDS;
    @(posedge CLK);
    params.r     <= dim_t'(golden[g+F_R]);
    params.s     <= dim_t'(golden[g+F_S]);
    params.tile  <= dim_t'(golden[g+F_TILE]);
    params.valid <= 1'b1;
    psum_base    <= golden[g+F_PBASE];
    output_base  <= golden[g+F_OBASE];
    @(posedge CLK);
    params.valid <= 1'b0;
    @(negedge CLK);
    for (int r = 0; r < PE_ROWS; r++) begin
      for (int c = 0; c < PE_COLS; c++) begin
        gold_bit = int'(golden[g+F_ADD][r*PE_COLS+c]);
        rule_bit = int'(r < int'(golden[g+F_R]) && c < int'(golden[g+F_S]));
        assert (gold_bit == rule_bit) else
          abort_run($sformatf("golden add mux bit %0d,%0d of test %0d is wrong", r, c, t));
        assert (int'(add_mux_ctrl[r][c]) == gold_bit) else
          report_mismatch($sformatf("add_mux_ctrl[%0d][%0d]", r, c),
                          word_t'(gold_bit), word_t'(add_mux_ctrl[r][c]));
      end
      assert (row_out_mux_ctrl[r] == row_sel_t'(golden[g+F_ROW])) else
        report_mismatch($sformatf("row_out_mux_ctrl[%0d]", r),
                        golden[g+F_ROW], word_t'(row_out_mux_ctrl[r]));
    end
    assert (psum_out_mux_ctrl == psum_sel_t'(golden[g+F_PSUM])) else
      report_mismatch("psum_out_mux_ctrl", golden[g+F_PSUM], word_t'(psum_out_mux_ctrl));
  endtask

  // one read burst with beats spaced by random gaps
  task automatic serve_read_burst(input int idx, input word_t base, input logic err);
    int gap;
    @(negedge CLK);
    while (!rd_cmd.init) @(negedge CLK);
    assert (rd_cmd.addr == base + word_t'(idx * BURST_BYTES)) else
      report_mismatch("rd_cmd.addr", base + word_t'(idx * BURST_BYTES), rd_cmd.addr);
    for (int b = 0; b < BURST_LEN; b++) begin
      gap = $urandom_range(0, 2);
      repeat (gap) begin
        @(posedge CLK);
        rd_beat.valid <= 1'b0;
      end
      @(posedge CLK);
      rd_beat.valid <= 1'b1;
      rd_beat.data  <= cur_mem[idx*BURST_LEN+b];
    end
    @(posedge CLK);
    rd_beat.valid <= 1'b0;
    txn_done      <= 1'b1;
    @(posedge CLK);
    txn_done  <= 1'b0;
    axi_error <= err;
    @(posedge CLK);
    axi_error <= 1'b0;
  endtask

  task automatic buffer_psums(input word_t base, input logic err);
    @(posedge CLK);
    mem_ctrl.buffer_psums <= 1'b1;
    for (int i = 0; i < PSUM_BURSTS; i++) begin
      serve_read_burst(i, base, err && (i == PSUM_BURSTS - 1));
    end
    mem_ctrl.buffer_psums <= 1'b0;
    watch_bus_idle(4);
    assert (pe_status.psums_buffered) else
      abort_run($sformatf("at %0t ns psums_buffered did not set", $time));
    assert (pe_status.psum_buffer_error == err) else
      report_mismatch("pe_status.psum_buffer_error", word_t'(err),
                      word_t'(pe_status.psum_buffer_error));
  endtask

  task automatic clear_psums();
    @(posedge CLK);
    mem_ctrl.clear_psum <= 1'b1;
    @(posedge CLK);
    mem_ctrl.clear_psum <= 1'b0;
  endtask

  // run with random activation gaps that checks stalls and psum order
  task automatic run_array(input int t);
    int run_len;
    int n_valid;
    run_len = MAC_PIPE_DEPTH
            + int'(golden[t*FIELDS+F_TILE]) * (int'(golden[t*FIELDS+F_R]) + 1);
    n_valid = 0;
    @(posedge CLK);
    params.start <= 1'b1;
    while (n_valid < run_len) begin
      @(posedge CLK);
      params.start <= 1'b0;
      act_valid    <= ($urandom_range(0, 3) != 0);
      @(negedge CLK);
      assert (stall_ctrl == !act_valid) else
        report_mismatch("stall_ctrl", word_t'(!act_valid), word_t'(stall_ctrl));
      if (act_valid) begin
        if (n_valid < PSUM_WORDS) begin
          assert (in_psum_out == cur_mem[n_valid]) else
            report_mismatch("in_psum_out", cur_mem[n_valid], in_psum_out);
        end
        n_valid++;
      end
    end
    @(posedge CLK);
    act_valid <= 1'b0;
    // output window opens right after the last counted cycle
    @(negedge CLK);
    out_first = out_psum_in;
    @(negedge CLK);
    assert (pe_status.output_buffering && pe_status.busy) else
      abort_run($sformatf("at %0t ns output buffering not reported after the run", $time));
  endtask

  task automatic serve_write_burst(input int idx, input word_t base);
    int gap;
    @(negedge CLK);
    while (!wr_cmd.init) @(negedge CLK);
    assert (wr_cmd.addr == base + word_t'(idx * BURST_BYTES)) else
      report_mismatch("wr_cmd.addr", base + word_t'(idx * BURST_BYTES), wr_cmd.addr);
    if (idx == 0) begin
      assert (!pe_status.output_written) else
        abort_run($sformatf("at %0t ns output_written still set from the last run", $time));
    end
    for (int b = 0; b < BURST_LEN; b++) begin
      gap = $urandom_range(0, 2);
      repeat (gap) begin
        @(posedge CLK);
        wr_accept <= 1'b0;
      end
      @(posedge CLK);
      wr_accept <= 1'b1;
      @(negedge CLK);
      written_q.push_back(wr_data);
    end
    @(posedge CLK);
    wr_accept <= 1'b0;
    txn_done  <= 1'b1;
    @(posedge CLK);
    txn_done <= 1'b0;
  endtask

  task automatic write_back(input word_t base);
    written_q.delete();
    for (int i = 0; i < OUT_BURSTS; i++) begin
      serve_write_burst(i, base);
    end
    // counter input gives consecutive words
    for (int i = 0; i < OUT_WORDS; i++) begin
      assert (written_q[i] == out_first + word_t'(i)) else
        report_mismatch($sformatf("wr_data beat %0d", i), out_first + word_t'(i),
                        written_q[i]);
    end
    watch_bus_idle(4);
    while (!pe_status.output_written) @(negedge CLK);
    assert (!pe_status.busy && !pe_status.output_write_error) else
      abort_run($sformatf("at %0t ns unit still busy or write error set", $time));
  endtask

  initial begin
    params      <= '0;
    psum_base   <= '0;
    output_base <= '0;
    mem_ctrl    <= '0;
    act_valid   <= 1'b0;
    rd_beat     <= '0;
    wr_accept   <= 1'b0;
    txn_done    <= 1'b0;
    axi_error   <= 1'b0;
    void'($urandom(44232));
    $readmemh("verification/pe_control_unit_golden.txt", golden);

    wait (resetn_all);
    @(negedge CLK);
    assert (!rd_cmd.init && !wr_cmd.init && !stall_ctrl && pe_status == '0
            && psum_out_mux_ctrl == '0) else
      abort_run("outputs are not idle after reset");
    for (int r = 0; r < PE_ROWS; r++) begin
      assert (add_mux_ctrl[r] == '0 && row_out_mux_ctrl[r] == '0) else
        abort_run($sformatf("mux controls of row %0d are not zero after reset", r));
    end

    for (int t = 0; t < NUM_TESTS; t++) begin
      apply_params(t);
      // inverted words first so a missed clear shows up in the feed
      if (golden[t*FIELDS+F_ERR][0]) begin
        load_psum_words(t, 1'b1);
        buffer_psums(golden[t*FIELDS+F_PBASE], 1'b1);
        clear_psums();
      end
      load_psum_words(t, 1'b0);
      buffer_psums(golden[t*FIELDS+F_PBASE], 1'b0);
      run_array(t);
      write_back(golden[t*FIELDS+F_OBASE]);
    end

    $display("Simulation completed successfully");
    $finish;
  end

  // watchdog sized from the number of test lines
  initial begin
    repeat (NUM_TESTS * CYCLES_PER_TEST) @(posedge CLK);
    abort_run("timeout: the tests did not finish within the cycle budget");
  end

endmodule

// File: verification/tb_clock_gen.sv
// ======================================================================
// testbench clock and synchronous reset generator
// ======================================================================
`timescale 1ns/1ps
module tb_clock_gen #(
  parameter int PERIOD_NS    = 8,
  parameter int RESET_CYCLES = 5
) (
  output logic CLK,
  output logic resetn_all
);

  initial begin
    CLK = 1'b0;
    forever #(PERIOD_NS / 2.0) CLK = ~CLK;
  end

  // reset low for a fixed number of rising edges
  initial begin
    resetn_all <= 1'b0;
    repeat (RESET_CYCLES) @(posedge CLK);
    resetn_all <= 1'b1;
  end

endmodule
